// ==== rtl/file_params.svh ====
/*
 * Shared constants for the file engine: descriptor layout, item size
 * codes, the status wrap bit and the sequencer state codes.
 */
`ifndef FILE_PARAMS_SVH
`define FILE_PARAMS_SVH

`define FILE_RAM_BASE     32'h0000_0400
`define FILE_DESC_STRIDE  32'h0000_0020

// descriptor word offsets in bytes
`define FILE_START_OFS    32'h00
`define FILE_END_OFS      32'h04
`define FILE_RD_PTR_OFS   32'h08
`define FILE_WR_PTR_OFS   32'h0C
`define FILE_STATUS_OFS   32'h10
`define FILE_CONTROL_OFS  32'h14

`define SIZE_UNDEFINED    2'd0
`define SIZE_BYTE         2'd1
`define SIZE_HWORD        2'd2
`define SIZE_WORD         2'd3

`define STATUS_WRAP_BIT   0

`define ST_IDLE           5'd0
`define ST_LOAD           5'd1
`define ST_DATA_RD        5'd2
`define ST_DATA_WR        5'd3
`define ST_REWIND         5'd4
`define ST_WB_STATUS      5'd5
`define ST_WB_RD_PTR      5'd6
`define ST_WB_WR_PTR      5'd7

`endif

// ==== rtl/file_pkg.sv ====
/*
 * Types for the file engine. A descriptor word read from memory is
 * decoded either as a plain address/status word or as the control word.
 */
package file_pkg;

   typedef struct packed {
      logic [29:0] reserved;
      logic [1:0]  data_size;   // one of the SIZE_* codes
   } ctl_word_t;

   // control word goes through ctl, every other word through raw
   typedef union packed {
      logic [31:0] raw;
      ctl_word_t   ctl;
   } desc_word_u;

endpackage

// ==== rtl/lane_steer.sv ====
/*
 * Byte-lane steering for one file item. Picks the lane select from the
 * item size and pointer low bits and moves the item into those lanes.
 */
`include "file_params.svh"

module lane_steer (
   input  logic [1:0]  data_size,
   input  logic [1:0]  ptr_low,
   input  logic [31:0] wdata,
   output logic [3:0]  lane_sel,
   output logic [31:0] lane_wdata
);

   always_comb begin
      lane_sel   = 4'h0;
      lane_wdata = 32'h0;
      case (data_size)
         `SIZE_WORD: begin
            lane_sel   = 4'hf;
            lane_wdata = wdata;
         end
         `SIZE_HWORD: begin
            if (ptr_low[1]) begin
               lane_sel   = 4'hc;
               lane_wdata = {wdata[15:0], 16'h0};
            end else begin
               lane_sel   = 4'h3;
               lane_wdata = {16'h0, wdata[15:0]};
            end
         end
         `SIZE_BYTE: begin
            lane_sel   = 4'h1 << ptr_low;
            lane_wdata = {24'h0, wdata[7:0]} << {ptr_low, 3'b000};
         end
         default: ;   // undefined size touches no lanes
      endcase
   end

endmodule

// ==== rtl/bus_master.sv ====
/*
 * Single-transfer bus master. Latches one transfer on xfer_go, raises
 * start until active is seen, then waits for active to drop and returns
 * the read word with a one-cycle xfer_done.
 */
module bus_master (
   input  logic        wb_clk,
   input  logic        reset_file,
   input  logic        xfer_go,
   input  logic [31:0] xfer_addr,
   input  logic        xfer_write,
   input  logic [31:0] xfer_wdata,
   input  logic [3:0]  xfer_sel,
   input  logic [31:0] data_rd,
   input  logic        active,
   output logic [31:0] address,
   output logic        start,
   output logic [3:0]  selection,
   output logic        write,
   output logic [31:0] data_wr,
   output logic        xfer_done,
   output logic [31:0] xfer_rdata
);

   logic wait_low;   // start dropped, waiting for active to fall
   logic finish;

   assign finish = wait_low && !active;

   always_ff @(posedge wb_clk) begin
      if (reset_file) begin
         address   <= 32'h0;
         start     <= 1'b0;
         selection <= 4'h0;
         write     <= 1'b0;
         wait_low  <= 1'b0;
         xfer_done <= 1'b0;
      end else begin
         xfer_done <= finish;
         if (xfer_go) begin
            address   <= xfer_addr;
            selection <= xfer_sel;
            write     <= xfer_write;
            start     <= 1'b1;
         end else if (start && active) begin
            start    <= 1'b0;
            wait_low <= 1'b1;
         end else if (finish) begin
            wait_low <= 1'b0;
         end
      end
   end

   always_ff @(posedge wb_clk) begin
      if (xfer_go) begin
         data_wr <= xfer_wdata;
      end
      if (finish) begin
         xfer_rdata <= data_rd;
      end
   end

endmodule

// ==== rtl/file_descriptor.sv ====
/*
 * Working copy of one file descriptor. Loaded word by word from memory,
 * then moves the read or write pointer with wrap, or rewinds both.
 */
`include "file_params.svh"

module file_descriptor
   import file_pkg::*;
(
   input  logic        wb_clk,
   input  logic        reset_file,
   input  logic [2:0]  load_field,
   input  logic        load_strobe,
   input  desc_word_u  load_word,
   input  logic        advance_rd,
   input  logic        advance_wr,
   input  logic        rewind,
   output logic [31:0] start_addr,
   output logic [31:0] end_addr,
   output logic [31:0] rd_ptr,
   output logic [31:0] wr_ptr,
   output logic [31:0] status,
   output logic [1:0]  data_size
);

   logic [31:0] incr;
   logic [31:0] ptr_sum;
   logic        wrap;
   logic [31:0] ptr_next;

   always_comb begin
      case (data_size)
         `SIZE_WORD:  incr = 32'd4;
         `SIZE_HWORD: incr = 32'd2;
         `SIZE_BYTE:  incr = 32'd1;
         default:     incr = 32'd0;
      endcase
   end

   // one adder shared by both pointers
   assign ptr_sum  = (advance_rd ? rd_ptr : wr_ptr) + incr;
   assign wrap     = ptr_sum > end_addr;
   assign ptr_next = wrap ? start_addr : ptr_sum;

   always_ff @(posedge wb_clk) begin
      if (reset_file) begin
         rd_ptr    <= 32'h0;
         wr_ptr    <= 32'h0;
         data_size <= `SIZE_UNDEFINED;
      end else if (load_strobe) begin
         case (load_field)
            3'd2: rd_ptr    <= load_word.raw;
            3'd3: wr_ptr    <= load_word.raw;
            3'd5: data_size <= load_word.ctl.data_size;
            default: ;
         endcase
      end else if (rewind) begin
         rd_ptr <= start_addr;
         wr_ptr <= start_addr;
      end else if (advance_rd) begin
         rd_ptr <= ptr_next;
      end else if (advance_wr) begin
         wr_ptr <= ptr_next;
      end
   end

   always_ff @(posedge wb_clk) begin
      if (load_strobe) begin
         case (load_field)
            3'd0: start_addr <= load_word.raw;
            3'd1: end_addr   <= load_word.raw;
            3'd4: status     <= load_word.raw;
            default: ;
         endcase
      end else if ((advance_rd | advance_wr) && wrap) begin
         status[`STATUS_WRAP_BIT] <= 1'b1;   // sticky, cleared only by software
      end
   end

endmodule

// ==== rtl/file_sequencer.sv ====
/*
 * Request sequencer. Loads the six descriptor words, does the data access
 * or the rewind, then writes status and the moved pointer(s) back.
 */
`include "file_params.svh"

module file_sequencer
   import file_pkg::*;
(
   input  logic        wb_clk,
   input  logic        reset_file,
   input  logic [7:0]  file_num,
   input  logic        file_read,
   input  logic        file_write,
   input  logic        file_reset,
   input  logic [31:0] file_write_data,
   input  logic        xfer_done,
   input  desc_word_u  xfer_rdata,
   input  logic [31:0] start_addr,
   input  logic [31:0] rd_ptr,
   input  logic [31:0] wr_ptr,
   input  logic [31:0] status,
   input  logic [3:0]  lane_sel,
   input  logic [31:0] lane_wdata,
   output logic        file_active,
   output logic [31:0] file_read_data,
   output logic        xfer_go,
   output logic [31:0] xfer_addr,
   output logic        xfer_write,
   output logic [31:0] xfer_wdata,
   output logic [3:0]  xfer_sel,
   output logic [2:0]  load_field,
   output logic        load_strobe,
   output logic        advance_rd,
   output logic        advance_wr,
   output logic        rewind,
   output logic [1:0]  steer_ptr_low,
   output logic [31:0] steer_wdata
);

   logic [4:0]  state;
   logic [2:0]  field_cnt;
   logic        req_read;     // read wins over write
   logic        req_reset;
   logic [31:0] base;
   logic [31:0] wdata_hold;

   function automatic logic [31:0] field_ofs(input logic [2:0] idx);
      case (idx)
         3'd0:    field_ofs = `FILE_START_OFS;
         3'd1:    field_ofs = `FILE_END_OFS;
         3'd2:    field_ofs = `FILE_RD_PTR_OFS;
         3'd3:    field_ofs = `FILE_WR_PTR_OFS;
         3'd4:    field_ofs = `FILE_STATUS_OFS;
         default: field_ofs = `FILE_CONTROL_OFS;
      endcase
   endfunction

   always_ff @(posedge wb_clk) begin
      if (reset_file) begin
         state          <= `ST_IDLE;
         field_cnt      <= 3'd0;
         req_read       <= 1'b0;
         req_reset      <= 1'b0;
         xfer_go        <= 1'b0;
         file_active    <= 1'b0;
         file_read_data <= 32'h0;
      end else begin
         xfer_go <= 1'b0;
         case (state)
            `ST_IDLE: begin
               if (file_read | file_write | file_reset) begin
                  state       <= `ST_LOAD;
                  field_cnt   <= 3'd0;
                  req_read    <= file_read;
                  req_reset   <= file_reset;
                  file_active <= 1'b1;
                  xfer_go     <= 1'b1;
               end
            end
            `ST_LOAD: begin
               if (xfer_done) begin
                  if (field_cnt == 3'd5) begin
                     if (req_reset) begin
                        state <= `ST_REWIND;   // no bus access for a rewind
                     end else begin
                        state   <= req_read ? `ST_DATA_RD : `ST_DATA_WR;
                        xfer_go <= 1'b1;
                     end
                  end else begin
                     field_cnt <= field_cnt + 3'd1;
                     xfer_go   <= 1'b1;
                  end
               end
            end
            `ST_REWIND: begin
               state   <= `ST_WB_STATUS;
               xfer_go <= 1'b1;
            end
            `ST_DATA_RD: begin
               if (xfer_done) begin
                  file_read_data <= xfer_rdata.raw;
                  state          <= `ST_WB_STATUS;
                  xfer_go        <= 1'b1;
               end
            end
            `ST_DATA_WR: begin
               if (xfer_done) begin
                  state   <= `ST_WB_STATUS;
                  xfer_go <= 1'b1;
               end
            end
            `ST_WB_STATUS: begin
               if (xfer_done) begin
                  state   <= (req_read | req_reset) ? `ST_WB_RD_PTR : `ST_WB_WR_PTR;
                  xfer_go <= 1'b1;
               end
            end
            `ST_WB_RD_PTR: begin
               if (xfer_done) begin
                  if (req_reset) begin
                     state   <= `ST_WB_WR_PTR;   // reset rewrites both pointers
                     xfer_go <= 1'b1;
                  end else begin
                     state       <= `ST_IDLE;
                     file_active <= 1'b0;
                  end
               end
            end
            `ST_WB_WR_PTR: begin
               if (xfer_done) begin
                  state       <= `ST_IDLE;
                  file_active <= 1'b0;
               end
            end
            default: state <= `ST_IDLE;
         endcase
      end
   end

   // request payload, taken with the request in idle
   always_ff @(posedge wb_clk) begin
      if (state == `ST_IDLE) begin
         base       <= `FILE_RAM_BASE + `FILE_DESC_STRIDE * {24'h0, file_num};
         wdata_hold <= file_write_data;
      end
   end

   assign load_field  = field_cnt;
   assign load_strobe = (state == `ST_LOAD) && xfer_done;
   assign advance_rd  = (state == `ST_DATA_RD) && xfer_done;
   assign advance_wr  = (state == `ST_DATA_WR) && xfer_done;
   assign rewind      = (state == `ST_REWIND);

   assign steer_ptr_low = req_read ? rd_ptr[1:0] : wr_ptr[1:0];
   assign steer_wdata   = wdata_hold;

   // transfer fields, sampled by the bus master while xfer_go is high
   always_comb begin
      xfer_addr  = base;
      xfer_write = 1'b0;
      xfer_wdata = 32'h0;
      xfer_sel   = 4'hf;
      case (state)
         `ST_LOAD: xfer_addr = base + field_ofs(field_cnt);
         `ST_DATA_RD: begin
            xfer_addr = rd_ptr;
            xfer_sel  = lane_sel;
         end
         `ST_DATA_WR: begin
            xfer_addr  = wr_ptr;
            xfer_write = 1'b1;
            xfer_wdata = lane_wdata;
            xfer_sel   = lane_sel;
         end
         `ST_WB_STATUS: begin
            xfer_addr  = base + `FILE_STATUS_OFS;
            xfer_write = 1'b1;
            xfer_wdata = status;
         end
         `ST_WB_RD_PTR: begin
            xfer_addr  = base + `FILE_RD_PTR_OFS;
            xfer_write = 1'b1;
            xfer_wdata = req_reset ? start_addr : rd_ptr;
         end
         `ST_WB_WR_PTR: begin
            xfer_addr  = base + `FILE_WR_PTR_OFS;
            xfer_write = 1'b1;
            xfer_wdata = req_reset ? start_addr : wr_ptr;
         end
         default: ;
      endcase
   end

endmodule

// ==== rtl/file_access_top.sv ====
/*
 * File engine top. Takes read, write and reset requests on a file number
 * and runs them against the descriptor memory over the start/active bus.
 */
module file_access_top
   import file_pkg::*;
(
   input  logic        wb_clk,
   input  logic        reset_file,
   input  logic [7:0]  file_num,
   input  logic        file_read,
   input  logic        file_write,
   input  logic        file_reset,
   input  logic [31:0] file_write_data,
   output logic [31:0] file_read_data,
   output logic        file_active,
   output logic [31:0] address,
   output logic        start,
   output logic [3:0]  selection,
   output logic        write,
   output logic [31:0] data_wr,
   input  logic [31:0] data_rd,
   input  logic        active,
   output logic [31:0] rd_ptr,
   output logic [31:0] wr_ptr
);

   logic        xfer_go;
   logic [31:0] xfer_addr;
   logic        xfer_write;
   logic [31:0] xfer_wdata;
   logic [3:0]  xfer_sel;
   logic        xfer_done;
   desc_word_u  xfer_rdata;

   logic [2:0]  load_field;
   logic        load_strobe;
   logic        advance_rd;
   logic        advance_wr;
   logic        rewind;
   logic [31:0] start_addr;
   logic [31:0] status;
   logic [1:0]  data_size;

   logic [3:0]  lane_sel;
   logic [31:0] lane_wdata;
   logic [1:0]  steer_ptr_low;
   logic [31:0] steer_wdata;

   file_sequencer i_seq (
      .wb_clk(wb_clk), .reset_file(reset_file),
      .file_num(file_num), .file_read(file_read), .file_write(file_write),
      .file_reset(file_reset), .file_write_data(file_write_data),
      .xfer_done(xfer_done), .xfer_rdata(xfer_rdata),
      .start_addr(start_addr), .rd_ptr(rd_ptr), .wr_ptr(wr_ptr), .status(status),
      .lane_sel(lane_sel), .lane_wdata(lane_wdata),
      .file_active(file_active), .file_read_data(file_read_data),
      .xfer_go(xfer_go), .xfer_addr(xfer_addr), .xfer_write(xfer_write),
      .xfer_wdata(xfer_wdata), .xfer_sel(xfer_sel),
      .load_field(load_field), .load_strobe(load_strobe),
      .advance_rd(advance_rd), .advance_wr(advance_wr), .rewind(rewind),
      .steer_ptr_low(steer_ptr_low), .steer_wdata(steer_wdata)
   );

   file_descriptor i_desc (
      .wb_clk(wb_clk), .reset_file(reset_file),
      .load_field(load_field), .load_strobe(load_strobe), .load_word(xfer_rdata),
      .advance_rd(advance_rd), .advance_wr(advance_wr), .rewind(rewind),
      .start_addr(start_addr), .end_addr(), .rd_ptr(rd_ptr), .wr_ptr(wr_ptr),
      .status(status), .data_size(data_size)
   );

   lane_steer i_steer (
      .data_size(data_size), .ptr_low(steer_ptr_low), .wdata(steer_wdata),
      .lane_sel(lane_sel), .lane_wdata(lane_wdata)
   );

   bus_master i_bus (
      .wb_clk(wb_clk), .reset_file(reset_file),
      .xfer_go(xfer_go), .xfer_addr(xfer_addr), .xfer_write(xfer_write),
      .xfer_wdata(xfer_wdata), .xfer_sel(xfer_sel),
      .data_rd(data_rd), .active(active),
      .address(address), .start(start), .selection(selection), .write(write),
      .data_wr(data_wr), .xfer_done(xfer_done), .xfer_rdata(xfer_rdata)
   );

endmodule

// ==== tests/mem_model.sv ====
/*
 * Bus memory for the file engine testbench. Answers start with active after
 * a random wait, holds active a random time, and writes by byte lane.
 */
module mem_model (
   input  logic        wb_clk,
   input  logic [31:0] address,
   input  logic        start,
   input  logic [3:0]  selection,
   input  logic        write,
   input  logic [31:0] data_wr,
   output logic [31:0] data_rd,
   output logic        active
);

   logic [31:0] mem [0:511];   // 2 KB, word addressed
   integer      seed;
   int          wait_cnt;
   int          phase;         // 0 idle, 1 waiting, 2 active
   logic        start_s;
   logic [31:0] addr_s;
   logic [3:0]  sel_s;
   logic        write_s;
   logic [31:0] wdata_s;

   initial begin
      seed     = 32'hfe1;
      phase    = 0;
      wait_cnt = 0;
      active   = 1'b0;
      data_rd  = 32'h0;
      for (int i = 0; i < 512; i++) begin
         mem[i] = 32'h5a00_0000 ^ (i * 32'h0001_0101);
      end
   end

   always @(posedge wb_clk) begin
      start_s = start;   // bus as seen at the edge
      addr_s  = address;
      sel_s   = selection;
      write_s = write;
      wdata_s = data_wr;
      #1;
      case (phase)
         0: begin
            if (start_s) begin
               wait_cnt = $random(seed) & 3;
               phase    = 1;
            end
         end
         1: begin
            if (wait_cnt > 0) begin
               wait_cnt = wait_cnt - 1;
            end else begin
               if (write_s) begin
                  for (int b = 0; b < 4; b++) begin
                     if (sel_s[b]) begin
                        mem[addr_s[10:2]][8*b +: 8] = wdata_s[8*b +: 8];
                     end
                  end
               end else begin
                  data_rd = mem[addr_s[10:2]];   // held until the next read
               end
               active   = 1'b1;
               wait_cnt = $random(seed) & 3;   // hold time once start drops
               phase    = 2;
            end
         end
         default: begin
            if (!start_s) begin
               if (wait_cnt > 0) begin
                  wait_cnt = wait_cnt - 1;
               end else begin
                  active = 1'b0;
                  phase  = 0;
               end
            end
         end
      endcase
   end

endmodule

// ==== tests/tb_file_access.sv ====
/*
 * Directed testbench for the file engine. Preloads descriptors into the bus
 * memory model, runs read, write and reset requests and checks the results.
 */
`include "file_params.svh"

module tb_file_access;

   localparam int REQ_COUNT  = 29;    // requests issued over all tests
   localparam int REQ_BUDGET = 200;   // cycles allowed per request

   logic        wb_clk;
   logic        reset_file;
   logic [7:0]  file_num;
   logic        file_read;
   logic        file_write;
   logic        file_reset;
   logic [31:0] file_write_data;
   logic [31:0] file_read_data;
   logic        file_active;
   logic [31:0] address;
   logic        start;
   logic [3:0]  selection;
   logic        write;
   logic [31:0] data_wr;
   logic [31:0] data_rd;
   logic        active;
   logic [31:0] rd_ptr;
   logic [31:0] wr_ptr;

   logic [3:0]  data_sel;   // lane select of the last data access
   string       test_name;
   integer      seed;
   logic [31:0] word_items [0:2];

   file_access_top i_dut (.*);

   mem_model i_mem (.*);

   initial begin
      wb_clk = 1'b0;
      forever #2 wb_clk = ~wb_clk;
   end

   always @(posedge wb_clk) begin
      if (start && address < `FILE_RAM_BASE) begin
         data_sel <= selection;
      end
   end

   initial begin
      repeat (REQ_COUNT * REQ_BUDGET + 20) @(posedge wb_clk);
      $display("Timeout: the requests did not finish within the cycle budget");
      $display("Simulation failed");
      $fatal(1);
   end

   task automatic check_value(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp) else begin
         $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
         $display("Simulation failed");
         $fatal(1);
      end
   endtask

   task automatic wait_cycle();
      @(posedge wb_clk);
      #1;
   endtask

   task automatic put_word(input logic [31:0] addr, input logic [31:0] data);
      i_mem.mem[addr[10:2]] = data;
   endtask

   function automatic logic [31:0] get_word(input logic [31:0] addr);
      return i_mem.mem[addr[10:2]];
   endfunction

   task automatic set_descriptor(input int num, input logic [31:0] first,
                                 input logic [31:0] last, input logic [1:0] size);
      logic [31:0] base;
      base = `FILE_RAM_BASE + `FILE_DESC_STRIDE * num;
      put_word(base + `FILE_START_OFS, first);
      put_word(base + `FILE_END_OFS, last);
      put_word(base + `FILE_RD_PTR_OFS, first);
      put_word(base + `FILE_WR_PTR_OFS, first);
      put_word(base + `FILE_STATUS_OFS, 32'h0);
      put_word(base + `FILE_CONTROL_OFS, {30'h0, size});
   endtask

   // hold the request until file_active rises, then wait for it to fall
   task automatic run_request(input logic [7:0] num, input logic rd, input logic wr,
                              input logic rst, input logic [31:0] wdata);
      file_num        = num;
      file_read       = rd;
      file_write      = wr;
      file_reset      = rst;
      file_write_data = wdata;
      do wait_cycle(); while (!file_active);
      file_read  = 1'b0;
      file_write = 1'b0;
      file_reset = 1'b0;
      do wait_cycle(); while (file_active);
   endtask

   task automatic test_reset_values();
      test_name = "reset values";
      check_value("start", 32'h0, {31'h0, start});
      check_value("write", 32'h0, {31'h0, write});
      check_value("file_active", 32'h0, {31'h0, file_active});
      check_value("selection", 32'h0, {28'h0, selection});
      check_value("address", 32'h0, address);
      check_value("rd_ptr", 32'h0, rd_ptr);
      check_value("wr_ptr", 32'h0, wr_ptr);
      check_value("file_read_data", 32'h0, file_read_data);
   endtask

   task automatic test_word_file();
      test_name = "word file";
      for (int i = 0; i < 3; i++) begin
         run_request(8'd0, 1'b0, 1'b1, 1'b0, word_items[i]);
         check_value("wr_ptr", 32'h100 + 4 * (i + 1), wr_ptr);
         check_value("memory word", word_items[i], get_word(32'h100 + 4 * i));
      end
      for (int i = 0; i < 3; i++) begin
         run_request(8'd0, 1'b1, 1'b0, 1'b0, 32'h0);
         check_value("read data", word_items[i], file_read_data);
         check_value("rd_ptr", 32'h100 + 4 * (i + 1), rd_ptr);
      end
   endtask

   task automatic test_lanes();
      logic [31:0] exp_word;
      logic [31:0] item;
      logic [3:0]  exp_sel;
      test_name = "byte lanes";
      exp_word = 32'h0;
      for (int i = 0; i < 4; i++) begin
         item = 32'hdead_be00 + 32'h11 * (i + 1);   // upper bits must not leak
         exp_word[8*i +: 8] = item[7:0];
         exp_sel = 4'h1 << i;
         run_request(8'd1, 1'b0, 1'b1, 1'b0, item);
         check_value("selection", {28'h0, exp_sel}, {28'h0, data_sel});
         check_value("memory word", exp_word, get_word(32'h200));
         check_value("wr_ptr", 32'h200 + i + 1, wr_ptr);
      end
      test_name = "half-word lanes";
      exp_word = 32'h0;
      for (int i = 0; i < 2; i++) begin
         item = (i == 0) ? 32'h1234_beef : 32'h5678_cafe;
         exp_word[16*i +: 16] = item[15:0];
         exp_sel = (i == 0) ? 4'h3 : 4'hc;
         run_request(8'd2, 1'b0, 1'b1, 1'b0, item);
         check_value("selection", {28'h0, exp_sel}, {28'h0, data_sel});
         check_value("memory word", exp_word, get_word(32'h280));
         check_value("wr_ptr", 32'h280 + 2 * (i + 1), wr_ptr);
      end
   endtask

   task automatic test_wrap();
      logic [31:0] desc;
      logic [31:0] exp_ptr;
      logic [31:0] status_word;
      test_name = "wrap";
      desc = `FILE_RAM_BASE + `FILE_DESC_STRIDE * 3;
      exp_ptr = 32'h300;
      for (int i = 0; i < 3; i++) begin
         run_request(8'd3, 1'b0, 1'b1, 1'b0, 32'h3000_0000 + i);
         exp_ptr = exp_ptr + 4;
         if (exp_ptr > 32'h308) begin
            exp_ptr = 32'h300;
         end
         check_value("wr_ptr", exp_ptr, wr_ptr);
         check_value("wr_ptr in memory", exp_ptr, get_word(desc + `FILE_WR_PTR_OFS));
         status_word = get_word(desc + `FILE_STATUS_OFS);
         check_value("status wrap bit", (i == 2) ? 32'h1 : 32'h0,
                     {31'h0, status_word[`STATUS_WRAP_BIT]});
      end
   endtask

   task automatic test_file_reset();
      test_name = "file reset";
      run_request(8'd0, 1'b0, 1'b0, 1'b1, 32'h0);
      check_value("rd_ptr", 32'h100, rd_ptr);
      check_value("wr_ptr", 32'h100, wr_ptr);
      check_value("rd_ptr in memory", 32'h100, get_word(`FILE_RAM_BASE + `FILE_RD_PTR_OFS));
      check_value("wr_ptr in memory", 32'h100, get_word(`FILE_RAM_BASE + `FILE_WR_PTR_OFS));
      run_request(8'd0, 1'b1, 1'b0, 1'b0, 32'h0);
      check_value("first item", word_items[0], file_read_data);
      check_value("rd_ptr", 32'h104, rd_ptr);
   endtask

   task automatic test_back_pressure();
      logic [31:0] expect_q [$];
      logic [31:0] item;
      test_name = "back pressure";
      for (int r = 0; r < 3; r++) begin
         for (int k = 0; k < 2; k++) begin
            item = $random(seed);
            expect_q.push_back(item);
            run_request(8'd4, 1'b0, 1'b1, 1'b0, item);
         end
         for (int k = 0; k < 2; k++) begin
            run_request(8'd4, 1'b1, 1'b0, 1'b0, 32'h0);
            check_value("read data", expect_q.pop_front(), file_read_data);
         end
      end
      // six words around the four-word ring at 0x340
      check_value("wr_ptr", 32'h348, wr_ptr);
      check_value("rd_ptr", 32'h348, rd_ptr);
   endtask

   initial begin
      seed            = 32'hfe1;
      word_items[0]   = 32'hcafe_0001;
      word_items[1]   = 32'h1234_5678;
      word_items[2]   = 32'h8000_00ff;
      test_name       = "setup";
      reset_file      = 1'b1;
      file_num        = 8'h0;
      file_read       = 1'b0;
      file_write      = 1'b0;
      file_reset      = 1'b0;
      file_write_data = 32'h0;
      @(posedge wb_clk);
      set_descriptor(0, 32'h100, 32'h13c, `SIZE_WORD);
      set_descriptor(1, 32'h200, 32'h21f, `SIZE_BYTE);
      set_descriptor(2, 32'h280, 32'h29f, `SIZE_HWORD);
      set_descriptor(3, 32'h300, 32'h308, `SIZE_WORD);   // three-word ring
      set_descriptor(4, 32'h340, 32'h34c, `SIZE_WORD);
      put_word(32'h200, 32'h0);
      put_word(32'h280, 32'h0);
      repeat (3) @(posedge wb_clk);
      #1;
      reset_file = 1'b0;

      test_reset_values();
      test_word_file();
      test_lanes();
      test_wrap();
      test_file_reset();
      test_back_pressure();

      $display("Simulation passed");
      $finish;
   end

endmodule

// ==== all.f ====
+incdir+rtl
rtl/file_pkg.sv
rtl/lane_steer.sv
rtl/bus_master.sv
rtl/file_descriptor.sv
rtl/file_sequencer.sv
rtl/file_access_top.sv
tests/mem_model.sv
tests/tb_file_access.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the file engine testbench with Verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_file_access

out=$(./obj_dir/Vtb_file_access || true)
echo "$out"
if grep -q "^Simulation passed$" <<< "$out"; then
   exit 0
else
   exit 1
fi
